//--- common/kbd_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PC keyboard constants
// PS/2 protocol bytes, XT port encodings
// and the line synchronizer depth
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef KBD_DEFINES_SVH
`define KBD_DEFINES_SVH

// Flip-flops per keyboard line synchronizer
`define KBD_SYNC_STAGES 2

// Set-2 prefix sent ahead of a key release
`define KBD_BREAK_PREFIX 8'hF0

// Reply presented after pb6 is released
`define KBD_SELF_TEST_CODE 8'hAA

`define KBD_BREAK_BIT 7 // pa bit marking a release

`endif

//--- common/kbd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Keyboard subsystem types
// Scan code, code strobe and the XT port
// controller states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package kbd_pkg;

	// One byte of scan code, set 2 or set 1
	typedef logic [7:0] scan_code_t;

	// Code plus its qualifier, passed from stage to stage
	typedef struct packed {
		logic       valid; // High for one clk per code
		scan_code_t code;
	} code_strobe_t;

	// XT port controller states
	typedef enum logic [2:0] {
		ST_IDLE,       // Waiting for a code
		ST_PRESENT,    // Code on pa, irq1 raised
		ST_WAIT_CLR,   // Host acknowledged, waiting for pb7 low
		ST_BREAK_WAIT, // F0 seen, next code is a release
		ST_PB6_LOW,    // Host holding keyboard clock low
		ST_PB6_REL     // Released, self-test reply pending
	} xt_state_e;

endpackage

`default_nettype wire

//--- design/ps2_receiver.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PS/2 receiver
// Oversamples keyboard clock and data,
// assembles 11-bit frames and checks them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "kbd_defines.svh"

module ps2_receiver (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ps2_clk,
	input  logic                  ps2_data,
	output kbd_pkg::code_strobe_t raw_code
);

	logic [`KBD_SYNC_STAGES-1:0] clk_sync;
	logic [`KBD_SYNC_STAGES-1:0] data_sync;
	logic                        clk_prev;
	logic                        clk_fall;
	logic                        data_bit;
	logic                        last_bit;
	logic                        frame_ok;
	logic [3:0]                  bit_cnt;
	logic [9:0]                  shift_reg; // Parity, data, start from MSB down
	logic                        code_valid;
	kbd_pkg::scan_code_t         code_q;

	// Both lines idle high, so synchronizers come out of reset at 1
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			clk_sync  <= '1;
			data_sync <= '1;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[`KBD_SYNC_STAGES-2:0], ps2_clk};
			data_sync <= {data_sync[`KBD_SYNC_STAGES-2:0], ps2_data};
			clk_prev  <= clk_sync[`KBD_SYNC_STAGES-1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[`KBD_SYNC_STAGES-1];
	assign data_bit = data_sync[`KBD_SYNC_STAGES-1];
	assign last_bit = (bit_cnt == 4'd10); // Stop bit position

	// Start low, odd parity over data and parity, stop high
	assign frame_ok = ~shift_reg[0] & (^shift_reg[9:1]) & data_bit;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt    <= '0;
			code_valid <= 1'b0;
		end else begin
			code_valid <= 1'b0;
			if (clk_fall) begin
				if (last_bit) begin
					bit_cnt    <= '0; // Restarts on bad frames too
					code_valid <= frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	// LSB first, so bits shift in from the top
	always_ff @(posedge clk) begin
		if (clk_fall && !last_bit) begin
			shift_reg <= {data_bit, shift_reg[9:1]};
		end
		if (clk_fall && last_bit) begin
			code_q <= shift_reg[8:1];
		end
	end

	assign raw_code = '{valid: code_valid, code: code_q};

endmodule

`default_nettype wire

//--- scan_translate/scan_translate.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Scan code translator
// Registered set-2 to set-1 lookup table
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module scan_translate (
	input  logic                  clk,
	input  logic                  rst_n,
	input  kbd_pkg::code_strobe_t raw_code,
	output kbd_pkg::code_strobe_t xt_code
);

	kbd_pkg::scan_code_t xlate;
	kbd_pkg::scan_code_t code_q;
	logic                valid_q;

	always_comb begin
		case (raw_code.code)
			8'h00: xlate = 8'hFF;
			8'h01: xlate = 8'h43; // F9
			8'h02: xlate = 8'h41;
			8'h03: xlate = 8'h3F;
			8'h04: xlate = 8'h3D;
			8'h05: xlate = 8'h3B; // F1
			8'h06: xlate = 8'h3C;
			8'h07: xlate = 8'h58;
			8'h08: xlate = 8'h64;
			8'h09: xlate = 8'h44;
			8'h0A: xlate = 8'h42;
			8'h0B: xlate = 8'h40;
			8'h0C: xlate = 8'h3E;
			8'h0D: xlate = 8'h0F; // Tab
			8'h0E: xlate = 8'h29;
			8'h0F: xlate = 8'h59;
			8'h10: xlate = 8'h65;
			8'h11: xlate = 8'h38; // Left Alt
			8'h12: xlate = 8'h2A; // Left Shift
			8'h13: xlate = 8'h70;
			8'h14: xlate = 8'h1D; // Left Ctrl
			8'h15: xlate = 8'h10;
			8'h16: xlate = 8'h02;
			8'h17: xlate = 8'h5A;
			8'h18: xlate = 8'h66;
			8'h19: xlate = 8'h71;
			8'h1A: xlate = 8'h2C;
			8'h1B: xlate = 8'h1F;
			8'h1C: xlate = 8'h1E; // A
			8'h1D: xlate = 8'h11;
			8'h1E: xlate = 8'h03;
			8'h1F: xlate = 8'h5B;
			8'h20: xlate = 8'h67;
			8'h21: xlate = 8'h2E;
			8'h22: xlate = 8'h2D;
			8'h23: xlate = 8'h20;
			8'h24: xlate = 8'h12;
			8'h25: xlate = 8'h05;
			8'h26: xlate = 8'h04;
			8'h27: xlate = 8'h5C;
			8'h28: xlate = 8'h68;
			8'h29: xlate = 8'h39; // Space
			8'h2A: xlate = 8'h2F;
			8'h2B: xlate = 8'h21;
			8'h2C: xlate = 8'h14;
			8'h2D: xlate = 8'h13;
			8'h2E: xlate = 8'h06;
			8'h2F: xlate = 8'h5D;
			8'h30: xlate = 8'h69;
			8'h31: xlate = 8'h31;
			8'h32: xlate = 8'h30;
			8'h33: xlate = 8'h23;
			8'h34: xlate = 8'h22;
			8'h35: xlate = 8'h15;
			8'h36: xlate = 8'h07;
			8'h37: xlate = 8'h5E;
			8'h38: xlate = 8'h6A;
			8'h39: xlate = 8'h72;
			8'h3A: xlate = 8'h32;
			8'h3B: xlate = 8'h24;
			8'h3C: xlate = 8'h16;
			8'h3D: xlate = 8'h08;
			8'h3E: xlate = 8'h09;
			8'h3F: xlate = 8'h5F;
			8'h40: xlate = 8'h6B;
			8'h41: xlate = 8'h33;
			8'h42: xlate = 8'h25;
			8'h43: xlate = 8'h17;
			8'h44: xlate = 8'h18;
			8'h45: xlate = 8'h0B;
			8'h46: xlate = 8'h0A;
			8'h47: xlate = 8'h60;
			8'h48: xlate = 8'h6C;
			8'h49: xlate = 8'h34;
			8'h4A: xlate = 8'h35;
			8'h4B: xlate = 8'h26;
			8'h4C: xlate = 8'h27;
			8'h4D: xlate = 8'h19;
			8'h4E: xlate = 8'h0C;
			8'h4F: xlate = 8'h61;
			8'h50: xlate = 8'h6D;
			8'h51: xlate = 8'h73;
			8'h52: xlate = 8'h28;
			8'h53: xlate = 8'h74;
			8'h54: xlate = 8'h1A;
			8'h55: xlate = 8'h0D;
			8'h56: xlate = 8'h62;
			8'h57: xlate = 8'h6E;
			8'h58: xlate = 8'h3A; // Caps Lock
			8'h59: xlate = 8'h36; // Right Shift
			8'h5A: xlate = 8'h1C; // Enter
			8'h5B: xlate = 8'h1B;
			8'h5C: xlate = 8'h75;
			8'h5D: xlate = 8'h2B;
			8'h5E: xlate = 8'h63;
			8'h5F: xlate = 8'h76;
			8'h60: xlate = 8'h55;
			8'h61: xlate = 8'h56;
			8'h62: xlate = 8'h77;
			8'h63: xlate = 8'h78;
			8'h64: xlate = 8'h79;
			8'h65: xlate = 8'h7A;
			8'h66: xlate = 8'h0E; // Backspace
			8'h67: xlate = 8'h7B;
			8'h68: xlate = 8'h7C;
			8'h69: xlate = 8'h4F;
			8'h6A: xlate = 8'h7D;
			8'h6B: xlate = 8'h4B;
			8'h6C: xlate = 8'h47;
			8'h6D: xlate = 8'h7E;
			8'h6E: xlate = 8'h7F;
			8'h6F: xlate = 8'h6F;
			8'h70: xlate = 8'h52; // Keypad block starts
			8'h71: xlate = 8'h53;
			8'h72: xlate = 8'h50;
			8'h73: xlate = 8'h4C;
			8'h74: xlate = 8'h4D;
			8'h75: xlate = 8'h48;
			8'h76: xlate = 8'h01; // Esc
			8'h77: xlate = 8'h45;
			8'h78: xlate = 8'h57;
			8'h79: xlate = 8'h4E;
			8'h7A: xlate = 8'h51;
			8'h7B: xlate = 8'h4A;
			8'h7C: xlate = 8'h37;
			8'h7D: xlate = 8'h49;
			8'h7E: xlate = 8'h46;
			8'h7F: xlate = 8'h54;
			8'h83: xlate = 8'h41; // F7 sits out of order in set 2
			8'h84: xlate = 8'h54;
			// Upper half passes through, F0 included
			default: xlate = raw_code.code;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= raw_code.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (raw_code.valid) begin
			code_q <= xlate; // Held until the next strobe
		end
	end

	assign xt_code = '{valid: valid_q, code: code_q};

endmodule

`default_nettype wire

//--- design/xt_port_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// XT keyboard port controller
// Presents codes on pa, raises irq1 and
// answers the pb6 self-test request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

`include "kbd_defines.svh"

module xt_port_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  pb6,
	input  logic                  pb7,
	input  kbd_pkg::code_strobe_t xt_code,
	output kbd_pkg::scan_code_t   pa,
	output logic                  irq1
);

	kbd_pkg::xt_state_e  state;
	kbd_pkg::scan_code_t break_code;
	logic                is_prefix;

	assign is_prefix = (xt_code.code == `KBD_BREAK_PREFIX);

	// Release codes carry the make code with the top bit set
	always_comb begin
		break_code = xt_code.code;
		break_code[`KBD_BREAK_BIT] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= kbd_pkg::ST_IDLE;
			pa    <= '0;
			irq1  <= 1'b0;
		end else if (!pb6) begin
			// Keyboard clock held low by the host, wins over everything
			state <= kbd_pkg::ST_PB6_LOW;
			irq1  <= 1'b0;
		end else begin
			case (state)
				kbd_pkg::ST_IDLE: begin
					if (xt_code.valid) begin
						if (is_prefix) begin
							state <= kbd_pkg::ST_BREAK_WAIT; // No interrupt for F0
						end else begin
							pa    <= xt_code.code;
							state <= kbd_pkg::ST_PRESENT;
						end
					end
				end

				kbd_pkg::ST_BREAK_WAIT: begin
					// Repeated F0 keeps waiting
					if (xt_code.valid && !is_prefix) begin
						pa    <= break_code;
						state <= kbd_pkg::ST_PRESENT;
					end
				end

				kbd_pkg::ST_PRESENT: begin
					if (pb7) begin
						irq1  <= 1'b0; // Host acknowledge
						state <= kbd_pkg::ST_WAIT_CLR;
					end else begin
						irq1 <= 1'b1;
					end
				end

				kbd_pkg::ST_WAIT_CLR: begin
					if (!pb7) begin
						pa    <= '0;
						state <= kbd_pkg::ST_IDLE;
					end
				end

				// pb6 is high here, so the host has let go
				kbd_pkg::ST_PB6_LOW: begin
					state <= kbd_pkg::ST_PB6_REL;
				end

				kbd_pkg::ST_PB6_REL: begin
					if (!pb7) begin
						pa    <= `KBD_SELF_TEST_CODE;
						state <= kbd_pkg::ST_PRESENT;
					end
				end

				default: begin
					state <= kbd_pkg::ST_IDLE;
					pa    <= '0;
					irq1  <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/pc_keyboard_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PC keyboard interface top
// PS/2 receiver, translator, XT port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module pc_keyboard_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ps2_clk,
	input  logic                ps2_data,
	input  logic                pb6,
	input  logic                pb7,
	output kbd_pkg::scan_code_t pa,
	output logic                irq1
);

	kbd_pkg::code_strobe_t raw_code; // Set-2 code from the keyboard
	kbd_pkg::code_strobe_t xt_code;  // Set-1 code, one cycle later

	ps2_receiver u_rx (
		.clk      (clk),
		.rst_n    (rst_n),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.raw_code (raw_code)
	);

	scan_translate u_xlate (
		.clk      (clk),
		.rst_n    (rst_n),
		.raw_code (raw_code),
		.xt_code  (xt_code)
	);

	xt_port_ctrl u_port (
		.clk     (clk),
		.rst_n   (rst_n),
		.pb6     (pb6),
		.pb7     (pb7),
		.xt_code (xt_code),
		.pa      (pa),
		.irq1    (irq1)
	);

endmodule

`default_nettype wire

//--- verification/tb_pc_keyboard.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// PC keyboard testbench
// Sends PS/2 frames from a table, acts as
// the XT host and checks pa and irq1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`default_nettype none

module tb_pc_keyboard;

	localparam int HALF_BIT     = 8; // clk cycles per ps2_clk half period
	localparam int FRAME_CYCLES = 11 * 2 * HALF_BIT;
	localparam int MAX_GAP      = 35;
	localparam int MARGIN       = 2 * FRAME_CYCLES + 64; // Break entries send two frames
	localparam int IRQ_LATENCY  = 6; // Stop-bit edge to irq1 high

	typedef enum logic [1:0] {
		KIND_MAKE,
		KIND_BREAK,
		KIND_BAD_PARITY,
		KIND_SELF_TEST
	} entry_kind_e;

	logic                clk = 1'b0;
	logic                rst_n;
	logic                ps2_clk;
	logic                ps2_data;
	logic                pb6;
	logic                pb7;
	kbd_pkg::scan_code_t pa;
	logic                irq1;

	// Set-1 values for set-2 codes 00 to 7F
	kbd_pkg::scan_code_t set1_ref [0:127] = '{
		8'hFF, 8'h43, 8'h41, 8'h3F, 8'h3D, 8'h3B, 8'h3C, 8'h58,
		8'h64, 8'h44, 8'h42, 8'h40, 8'h3E, 8'h0F, 8'h29, 8'h59,
		8'h65, 8'h38, 8'h2A, 8'h70, 8'h1D, 8'h10, 8'h02, 8'h5A,
		8'h66, 8'h71, 8'h2C, 8'h1F, 8'h1E, 8'h11, 8'h03, 8'h5B,
		8'h67, 8'h2E, 8'h2D, 8'h20, 8'h12, 8'h05, 8'h04, 8'h5C,
		8'h68, 8'h39, 8'h2F, 8'h21, 8'h14, 8'h13, 8'h06, 8'h5D,
		8'h69, 8'h31, 8'h30, 8'h23, 8'h22, 8'h15, 8'h07, 8'h5E,
		8'h6A, 8'h72, 8'h32, 8'h24, 8'h16, 8'h08, 8'h09, 8'h5F,
		8'h6B, 8'h33, 8'h25, 8'h17, 8'h18, 8'h0B, 8'h0A, 8'h60,
		8'h6C, 8'h34, 8'h35, 8'h26, 8'h27, 8'h19, 8'h0C, 8'h61,
		8'h6D, 8'h73, 8'h28, 8'h74, 8'h1A, 8'h0D, 8'h62, 8'h6E,
		8'h3A, 8'h36, 8'h1C, 8'h1B, 8'h75, 8'h2B, 8'h63, 8'h76,
		8'h55, 8'h56, 8'h77, 8'h78, 8'h79, 8'h7A, 8'h0E, 8'h7B,
		8'h7C, 8'h4F, 8'h7D, 8'h4B, 8'h47, 8'h7E, 8'h7F, 8'h6F,
		8'h52, 8'h53, 8'h50, 8'h4C, 8'h4D, 8'h48, 8'h01, 8'h45,
		8'h57, 8'h4E, 8'h51, 8'h4A, 8'h37, 8'h49, 8'h46, 8'h54
	};

	// Stimulus table, one column per queue
	string               name_q[$];
	entry_kind_e         kind_q[$];
	kbd_pkg::scan_code_t code_q[$];
	kbd_pkg::scan_code_t expected_q[$];

	logic [31:0] rng           = 32'd19870;
	int          cycle_count   = 0;
	int          timeout_limit = 0;

	pc_keyboard_top uut (
		.clk      (clk),
		.rst_n    (rst_n),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data),
		.pb6      (pb6),
		.pb7      (pb7),
		.pa       (pa),
		.irq1     (irq1)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
			stop_on_error("timeout waiting for irq1");
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic random_range(input int base, input int span, output int value);
		rng   = xorshift32(rng);
		value = base + int'(rng % 32'(span));
	endtask

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_code(input string name, input kbd_pkg::scan_code_t expected,
		input kbd_pkg::scan_code_t actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("Fail %s: pa expected %02h actual %02h",
				name, expected, actual));
		end
	endtask

	task automatic check_irq(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_on_error($sformatf("Fail %s: irq1 expected %0b actual %0b",
				name, expected, actual));
		end
	endtask

	task automatic check_latency(input string name, input int expected, input int actual);
		if (actual != expected) begin
			stop_on_error($sformatf("Fail %s: irq1 latency expected %0d actual %0d",
				name, expected, actual));
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Leaves ps2_clk low after the stop-bit edge
	task automatic send_frame(input kbd_pkg::scan_code_t code, input logic bad_parity);
		logic [10:0] frame;
		frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0}; // Stop, parity, data, start
		for (int i = 0; i < 11; i++) begin
			ps2_clk  = 1'b1;
			ps2_data = frame[i];
			wait_cycles(HALF_BIT);
			ps2_clk = 1'b0; // Data valid on this edge
			if (i < 10) begin
				wait_cycles(HALF_BIT);
			end
		end
	endtask

	task automatic wait_irq(output int cycles);
		cycles = 0;
		while (irq1 !== 1'b1) begin
			@(negedge clk);
			cycles++;
		end
	endtask

	task automatic watch_quiet(input string name, input int n);
		repeat (n) begin
			@(negedge clk);
			check_irq(name, 1'b0, irq1);
			check_code(name, 8'h00, pa);
		end
	endtask

	// Host side: read pa on irq1, then acknowledge with pb7
	task automatic present_and_clear(input string name, input kbd_pkg::scan_code_t expected,
		input int latency);
		int cycles;
		int hold;
		int gap;
		wait_irq(cycles);
		if (latency > 0) begin
			check_latency(name, latency, cycles);
		end
		check_code(name, expected, pa);
		random_range(1, 4, hold);
		pb7 = 1'b1;
		wait_cycles(1);
		check_irq(name, 1'b0, irq1);
		check_code(name, expected, pa); // Held until pb7 falls
		wait_cycles(hold - 1);
		pb7 = 1'b0;
		wait_cycles(1);
		check_code(name, 8'h00, pa);
		random_range(4, MAX_GAP - 3, gap);
		wait_cycles(gap);
	endtask

	task automatic add_entry(input string name, input entry_kind_e kind,
		input kbd_pkg::scan_code_t code, input kbd_pkg::scan_code_t expected);
		name_q.push_back(name);
		kind_q.push_back(kind);
		code_q.push_back(code);
		expected_q.push_back(expected);
	endtask

	task automatic build_table();
		for (int c = 0; c < 128; c++) begin
			if (c == 64) begin
				add_entry("bad_parity_1c", KIND_BAD_PARITY, 8'h1C, 8'h00);
			end
			add_entry($sformatf("make_%02h", c), KIND_MAKE, 8'(c), set1_ref[c]);
		end
		add_entry("make_83", KIND_MAKE, 8'h83, 8'h41);
		add_entry("make_84", KIND_MAKE, 8'h84, 8'h54);
		// Release codes: set-1 value with bit 7 set
		add_entry("break_1c", KIND_BREAK, 8'h1C, 8'h9E);
		add_entry("break_12", KIND_BREAK, 8'h12, 8'hAA);
		add_entry("break_76", KIND_BREAK, 8'h76, 8'h81);
		add_entry("break_83", KIND_BREAK, 8'h83, 8'hC1);
		add_entry("bad_parity_5a", KIND_BAD_PARITY, 8'h5A, 8'h00);
		add_entry("make_5a_after_bad", KIND_MAKE, 8'h5A, 8'h1C);
		add_entry("self_test", KIND_SELF_TEST, 8'h00, 8'hAA);
		add_entry("make_29_after_self_test", KIND_MAKE, 8'h29, 8'h39);
	endtask

	task automatic run_entry(input int idx);
		int hold;
		case (kind_q[idx])
			KIND_MAKE: begin
				send_frame(code_q[idx], 1'b0);
				present_and_clear(name_q[idx], expected_q[idx], IRQ_LATENCY);
			end
			KIND_BREAK: begin
				send_frame(8'hF0, 1'b0);
				watch_quiet(name_q[idx], 4 * IRQ_LATENCY); // Prefix alone stays silent
				send_frame(code_q[idx], 1'b0);
				present_and_clear(name_q[idx], expected_q[idx], IRQ_LATENCY);
			end
			KIND_BAD_PARITY: begin
				send_frame(code_q[idx], 1'b1);
				watch_quiet(name_q[idx], FRAME_CYCLES);
			end
			default: begin
				random_range(4, 8, hold);
				pb6 = 1'b0;
				wait_cycles(hold);
				pb6 = 1'b1;
				present_and_clear(name_q[idx], expected_q[idx], 0);
			end
		endcase
	endtask

	initial begin
		rst_n    = 1'b0;
		ps2_clk  = 1'b1;
		ps2_data = 1'b1;
		pb6      = 1'b1;
		pb7      = 1'b0;
		build_table();
		timeout_limit = name_q.size() * (FRAME_CYCLES + MAX_GAP + MARGIN) + 16;
		wait_cycles(5);
		rst_n = 1'b1;
		wait_cycles(1);
		check_code("reset", 8'h00, pa);
		check_irq("reset", 1'b0, irq1);
		for (int i = 0; i < name_q.size(); i++) begin
			run_entry(i);
		end
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+common
common/kbd_pkg.sv
design/ps2_receiver.sv
scan_translate/scan_translate.sv
design/xt_port_ctrl.sv
design/pc_keyboard_top.sv
verification/tb_pc_keyboard.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := tb_pc_keyboard
LINT_TOP  := pc_keyboard_top
FILELIST  := project.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
